//--- include/alu_settings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Width of one data word through the ALU and the register file
`define DATA_W 8

// Number of general purpose registers
`define ALU_REG_COUNT 4

// Bits needed to select one of the registers
`define ALU_REG_SEL_W 2

`endif

//--- design/alu_types_pkg.sv
`include "alu_settings.svh"

package alu_types_pkg;

    // One data word and the full width product of two words
    typedef logic [`DATA_W-1:0]   data_t;
    typedef logic [2*`DATA_W-1:0] product_t;

    // Opcode as seen by the ALU, the encoding is sparse
    typedef logic [4:0] alu_op_t;

    // Pass and constant operations
    localparam alu_op_t OP_A            = 5'd0;
    localparam alu_op_t OP_B            = 5'd1;
    localparam alu_op_t OP_0            = 5'd2;

    // Single operand arithmetic, these drive the carry flag
    localparam alu_op_t OP_MINUS_A      = 5'd3;
    localparam alu_op_t OP_MINUS_B      = 5'd4;
    localparam alu_op_t OP_A_PLUS_1     = 5'd5;
    localparam alu_op_t OP_B_PLUS_1     = 5'd6;
    localparam alu_op_t OP_A_MINUS_1    = 5'd7;
    localparam alu_op_t OP_B_MINUS_1    = 5'd8;

    // Two operand arithmetic with carry-in
    localparam alu_op_t OP_A_PLUS_B     = 5'd9;
    localparam alu_op_t OP_A_MINUS_B    = 5'd10;

    // Value 11 is not implemented and decodes as illegal

    // Product halves
    localparam alu_op_t OP_A_TIMES_B_HI = 5'd16;
    localparam alu_op_t OP_A_TIMES_B_LO = 5'd17;

    // Bitwise logic
    localparam alu_op_t OP_A_AND_B      = 5'd25;
    localparam alu_op_t OP_A_OR_B       = 5'd26;

endpackage

//--- design/cpu_instr_pkg.sv
`include "alu_settings.svh"

package cpu_instr_pkg;

    import alu_types_pkg::*;

    // Index into the register file
    typedef logic [`ALU_REG_SEL_W-1:0] reg_sel_t;

    // One execute instruction as delivered with the strobe
    typedef struct packed {
        alu_op_t  op;
        reg_sel_t dst;
        reg_sel_t src_a;
        reg_sel_t src_b;
        // Take imm instead of register src_b as the y operand
        logic     use_imm;
        // Feed the stored carry into add and subtract
        logic     use_carry;
        data_t    imm;
    } instr_t;

    // Both flags are active low
    typedef struct packed {
        logic carry_n;
        logic zero_n;
    } flags_t;

endpackage

//--- design/alu.sv
`timescale 1ns/1ps

`include "alu_settings.svh"

module alu (
    input  alu_types_pkg::data_t   x,
    input  alu_types_pkg::data_t   y,
    input  alu_types_pkg::alu_op_t op,
    input  logic                   carry_in_n,
    output alu_types_pkg::data_t   result,
    output cpu_instr_pkg::flags_t  flags,
    output logic                   illegal_op
);

    import alu_types_pkg::*;

    // Nine bit intermediate, the top bit becomes the carry
    logic [`DATA_W:0] tmp;
    logic [`DATA_W:0] cin_ext;
    product_t         prod;
    data_t            res;

    // The carry-in pin is active low, so a low level adds one
    assign cin_ext = {{`DATA_W{1'b0}}, ~carry_in_n};

    // One multiplier serves both product halves
    assign prod = x * y;

    always_comb begin
        tmp        = '0;
        res        = '0;
        illegal_op = 1'b0;
        case (op)
            OP_A: begin
                res = x;
            end
            OP_B: begin
                res = y;
            end
            OP_0: begin
                res = '0;
            end
            OP_MINUS_A: begin
                tmp = -{1'b0, x};
                res = tmp[`DATA_W-1:0];
            end
            OP_MINUS_B: begin
                tmp = -{1'b0, y};
                res = tmp[`DATA_W-1:0];
            end
            OP_A_PLUS_1: begin
                tmp = {1'b0, x} + 1'b1;
                res = tmp[`DATA_W-1:0];
            end
            OP_B_PLUS_1: begin
                tmp = {1'b0, y} + 1'b1;
                res = tmp[`DATA_W-1:0];
            end
            OP_A_MINUS_1: begin
                tmp = {1'b0, x} - 1'b1;
                res = tmp[`DATA_W-1:0];
            end
            OP_B_MINUS_1: begin
                tmp = {1'b0, y} - 1'b1;
                res = tmp[`DATA_W-1:0];
            end
            OP_A_PLUS_B: begin
                tmp = {1'b0, x} + {1'b0, y} + cin_ext;
                res = tmp[`DATA_W-1:0];
            end
            OP_A_MINUS_B: begin
                // Borrow shows up as the top bit of the wrapped difference
                tmp = {1'b0, x} - {1'b0, y} - cin_ext;
                res = tmp[`DATA_W-1:0];
            end
            OP_A_TIMES_B_HI: begin
                res = prod[2*`DATA_W-1:`DATA_W];
            end
            OP_A_TIMES_B_LO: begin
                res = prod[`DATA_W-1:0];
            end
            OP_A_AND_B: begin
                res = x & y;
            end
            OP_A_OR_B: begin
                res = x | y;
            end
            default: begin
                illegal_op = 1'b1;
            end
        endcase
    end

    assign result = res;

    // Non-arithmetic ops leave tmp at zero, which reads as no carry
    assign flags = '{carry_n: ~tmp[`DATA_W], zero_n: (res != '0)};

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

`include "alu_settings.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    arst_n,
    input  cpu_instr_pkg::reg_sel_t rd_sel_a,
    input  cpu_instr_pkg::reg_sel_t rd_sel_b,
    output alu_types_pkg::data_t    rd_a,
    output alu_types_pkg::data_t    rd_b,
    input  logic                    wr_en,
    input  cpu_instr_pkg::reg_sel_t wr_sel,
    input  alu_types_pkg::data_t    wr_data
);

    import alu_types_pkg::*;

    data_t regs [`ALU_REG_COUNT];

    // Both read ports see a write only after the clock edge
    assign rd_a = regs[rd_sel_a];
    assign rd_b = regs[rd_sel_b];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // An unknown write would silently poison every later read of that register
    a_wr_data_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> !$isunknown({wr_sel, wr_data})
    ) else $error("reg_file write with unknown select or data");

endmodule

//--- design/alu_exec_stage.sv
`timescale 1ns/1ps

module alu_exec_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  cpu_instr_pkg::instr_t   instr,
    input  logic                    instr_valid,
    output cpu_instr_pkg::reg_sel_t rd_sel_a,
    output cpu_instr_pkg::reg_sel_t rd_sel_b,
    input  alu_types_pkg::data_t    rd_a,
    input  alu_types_pkg::data_t    rd_b,
    output alu_types_pkg::data_t    operand_x,
    output alu_types_pkg::data_t    operand_y,
    output alu_types_pkg::alu_op_t  op,
    output logic                    carry_in_n,
    input  alu_types_pkg::data_t    alu_result,
    input  cpu_instr_pkg::flags_t   alu_flags,
    input  logic                    illegal_op,
    output logic                    wr_en,
    output cpu_instr_pkg::reg_sel_t wr_sel,
    output alu_types_pkg::data_t    wr_data,
    output alu_types_pkg::data_t    result,
    output cpu_instr_pkg::flags_t   flags,
    output logic                    result_valid,
    output logic                    op_error
);

    import cpu_instr_pkg::*;

    // Neither flag asserted
    localparam flags_t FLAGS_IDLE = '{carry_n: 1'b1, zero_n: 1'b1};

    logic commit;

    // Register reads follow the source fields directly
    assign rd_sel_a = instr.src_a;
    assign rd_sel_b = instr.src_b;

    assign operand_x = rd_a;
    assign operand_y = instr.use_imm ? instr.imm : rd_b;
    assign op        = instr.op;

    // Chained carry comes from the flags of the last legal instruction
    assign carry_in_n = instr.use_carry ? flags.carry_n : 1'b1;

    // An illegal opcode must leave registers and flags untouched
    assign commit = instr_valid && !illegal_op;

    assign wr_en   = commit;
    assign wr_sel  = instr.dst;
    assign wr_data = alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result       <= '0;
            flags        <= FLAGS_IDLE;
            result_valid <= 1'b0;
            op_error     <= 1'b0;
        end else begin
            result_valid <= commit;
            op_error     <= instr_valid && illegal_op;
            if (commit) begin
                result <= alu_result;
                flags  <= alu_flags;
            end
        end
    end

    // An instruction with unknown fields would decide the strobes and the write-back on garbage
    a_instr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        instr_valid |-> !$isunknown(instr)
    ) else $error("instr_valid high with unknown instruction fields");

    // Each output strobe traces back to an input strobe one cycle earlier
    a_strobe_follows_instr: assert property (
        @(posedge clk) disable iff (!arst_n)
        (result_valid || op_error) |-> $past(instr_valid)
    ) else $error("Output strobe without a preceding instr_valid");

endmodule

//--- design/alu_datapath.sv
`timescale 1ns/1ps

module alu_datapath (
    input  logic                  clk,
    input  logic                  arst_n,
    input  cpu_instr_pkg::instr_t instr,
    input  logic                  instr_valid,
    output alu_types_pkg::data_t  result,
    output cpu_instr_pkg::flags_t flags,
    output logic                  result_valid,
    output logic                  op_error
);

    import alu_types_pkg::*;
    import cpu_instr_pkg::*;

    // Register file read and write ports
    reg_sel_t rd_sel_a;
    reg_sel_t rd_sel_b;
    data_t    rd_a;
    data_t    rd_b;
    logic     wr_en;
    reg_sel_t wr_sel;
    data_t    wr_data;

    // ALU operands and results
    data_t    operand_x;
    data_t    operand_y;
    alu_op_t  op;
    logic     carry_in_n;
    data_t    alu_result;
    flags_t   alu_flags;
    logic     illegal_op;

    reg_file reg_file_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_sel_a (rd_sel_a),
        .rd_sel_b (rd_sel_b),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data)
    );

    alu_exec_stage alu_exec_stage_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .rd_sel_a     (rd_sel_a),
        .rd_sel_b     (rd_sel_b),
        .rd_a         (rd_a),
        .rd_b         (rd_b),
        .operand_x    (operand_x),
        .operand_y    (operand_y),
        .op           (op),
        .carry_in_n   (carry_in_n),
        .alu_result   (alu_result),
        .alu_flags    (alu_flags),
        .illegal_op   (illegal_op),
        .wr_en        (wr_en),
        .wr_sel       (wr_sel),
        .wr_data      (wr_data),
        .result       (result),
        .flags        (flags),
        .result_valid (result_valid),
        .op_error     (op_error)
    );

    alu alu_i (
        .x          (operand_x),
        .y          (operand_y),
        .op         (op),
        .carry_in_n (carry_in_n),
        .result     (alu_result),
        .flags      (alu_flags),
        .illegal_op (illegal_op)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released on a rising edge after the given number of cycles
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- bench/tb_alu_datapath.sv
`timescale 1ns/1ps

`include "alu_settings.svh"

module tb_alu_datapath;

    import alu_types_pkg::*;
    import cpu_instr_pkg::*;

    localparam int N_ARITH   = 300;
    localparam int N_LOGIC   = 200;
    localparam int N_CHAIN   = 100;
    localparam int N_ILLEGAL = 40;

    // One cycle per instruction, one flush cycle per test, plus some slack
    localparam int CYCLE_LIMIT = 8 + (2 * `ALU_REG_COUNT + 1) + (N_ARITH + 1)
        + (N_LOGIC + 1) + (N_CHAIN + 1) + (2 * N_ILLEGAL + 1) + 50;

    logic   clk;
    logic   arst_n;
    instr_t instr;
    logic   instr_valid;
    data_t  result;
    flags_t flags;
    logic   result_valid;
    logic   op_error;

    logic [31:0] lfsr_state = 32'hb68b_aaac;

    // Reference state: registers, stored flags and the last committed result
    data_t  m_regs [`ALU_REG_COUNT];
    flags_t m_flags;
    data_t  m_result;

    // Expected outputs for the instruction that the DUT samples next
    logic   exp_valid;
    logic   exp_error;
    data_t  exp_result;
    flags_t exp_flags;

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;
    int cycle_count = 0;

    alu_op_t arith_ops [8] = '{OP_MINUS_A, OP_MINUS_B, OP_A_PLUS_1, OP_B_PLUS_1,
                               OP_A_MINUS_1, OP_B_MINUS_1, OP_A_PLUS_B, OP_A_MINUS_B};
    alu_op_t logic_ops [7] = '{OP_A_TIMES_B_HI, OP_A_TIMES_B_LO, OP_A_AND_B, OP_A_OR_B,
                               OP_A, OP_B, OP_0};
    alu_op_t bad_ops [4]   = '{5'd11, 5'd15, 5'd20, 5'd31};

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(2)) tb_clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    alu_datapath alu_datapath_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .result       (result),
        .flags        (flags),
        .result_valid (result_valid),
        .op_error     (op_error)
    );

    // Galois LFSR, one step for every bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    function automatic instr_t random_instr(input alu_op_t op);
        instr_t t;
        t.op        = op;
        t.dst       = rand_bits(`ALU_REG_SEL_W);
        t.src_a     = rand_bits(`ALU_REG_SEL_W);
        t.src_b     = rand_bits(`ALU_REG_SEL_W);
        t.use_imm   = rand_bits(1);
        t.use_carry = rand_bits(1);
        t.imm       = rand_bits(`DATA_W);
        return t;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Works out the effect of one instruction from the ALU rules
    task automatic apply_model(input instr_t in);
        data_t x;
        data_t y;
        data_t res;
        int    v;
        int    cin;
        logic  arith;
        logic  legal;
        x     = m_regs[in.src_a];
        y     = in.use_imm ? in.imm : m_regs[in.src_b];
        cin   = (in.use_carry && !m_flags.carry_n) ? 1 : 0;
        v     = 0;
        arith = 1'b1;
        legal = 1'b1;
        case (in.op)
            OP_MINUS_A:      v = 0 - int'(x);
            OP_MINUS_B:      v = 0 - int'(y);
            OP_A_PLUS_1:     v = int'(x) + 1;
            OP_B_PLUS_1:     v = int'(y) + 1;
            OP_A_MINUS_1:    v = int'(x) - 1;
            OP_B_MINUS_1:    v = int'(y) - 1;
            OP_A_PLUS_B:     v = int'(x) + int'(y) + cin;
            OP_A_MINUS_B:    v = int'(x) - int'(y) - cin;
            default:         arith = 1'b0;
        endcase
        if (!arith) begin
            case (in.op)
                OP_A:            v = int'(x);
                OP_B:            v = int'(y);
                OP_0:            v = 0;
                OP_A_TIMES_B_HI: v = (int'(x) * int'(y)) >> `DATA_W;
                OP_A_TIMES_B_LO: v = int'(x) * int'(y);
                OP_A_AND_B:      v = int'(x & y);
                OP_A_OR_B:       v = int'(x | y);
                default:         legal = 1'b0;
            endcase
        end
        exp_valid = legal;
        exp_error = !legal;
        if (legal) begin
            res              = v[`DATA_W-1:0];
            m_regs[in.dst]   = res;
            m_result         = res;
            // Bit DATA_W of the wrapped sum is the carry or borrow out
            m_flags.carry_n  = arith ? !v[`DATA_W] : 1'b1;
            m_flags.zero_n   = (res != '0);
        end
        exp_result = m_result;
        exp_flags  = m_flags;
    endtask

    // Drives one cycle and checks what the DUT sampled on this edge
    task automatic step_cycle(input instr_t in, input logic valid);
        @(posedge clk);
        instr       <= in;
        instr_valid <= valid;
        @(negedge clk);
        check_value("result_valid", result_valid, exp_valid);
        check_value("op_error", op_error, exp_error);
        check_value("result", result, exp_result);
        check_value("flags.carry_n", flags.carry_n, exp_flags.carry_n);
        check_value("flags.zero_n", flags.zero_n, exp_flags.zero_n);
        exp_valid = 1'b0;
        exp_error = 1'b0;
        if (valid) begin
            apply_model(in);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        step_cycle('0, 1'b0);
        $display("Test %0d %s finished with %0d mismatches", test_count, name,
                 error_count - errors_before);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        instr_t t;
        alu_op_t op;
        reg_sel_t prev_dst;
        int errs;
        int i;
        instr       = '0;
        instr_valid = 1'b0;
        m_regs      = '{default: '0};
        m_flags     = '{carry_n: 1'b1, zero_n: 1'b1};
        m_result    = '0;
        exp_valid   = 1'b0;
        exp_error   = 1'b0;
        exp_result  = '0;
        exp_flags   = m_flags;
        wait (arst_n === 1'b1);

        errs = error_count;
        finish_test("reset state", errs);

        errs = error_count;
        for (i = 0; i < `ALU_REG_COUNT; i++) begin
            t         = random_instr(OP_B);
            t.dst     = i;
            t.use_imm = 1'b1;
            step_cycle(t, 1'b1);
        end
        for (i = 0; i < `ALU_REG_COUNT; i++) begin
            t       = random_instr(OP_A);
            t.src_a = i;
            t.dst   = i;
            step_cycle(t, 1'b1);
        end
        finish_test("immediate loads", errs);

        errs = error_count;
        for (i = 0; i < N_ARITH; i++) begin
            step_cycle(random_instr(arith_ops[rand_bits(3)]), 1'b1);
        end
        finish_test("arithmetic and flags", errs);

        errs = error_count;
        for (i = 0; i < N_LOGIC; i++) begin
            step_cycle(random_instr(logic_ops[rand_bits(3) % 7]), 1'b1);
        end
        finish_test("multiply and logic", errs);

        // Every source A is the register written one cycle before
        errs = error_count;
        prev_dst = '0;
        for (i = 0; i < N_CHAIN; i++) begin
            if (rand_bits(1)) begin
                op = arith_ops[rand_bits(3)];
            end else begin
                op = logic_ops[rand_bits(3) % 7];
            end
            t        = random_instr(op);
            t.src_a  = prev_dst;
            prev_dst = t.dst;
            step_cycle(t, 1'b1);
        end
        finish_test("back-to-back dependence", errs);

        errs = error_count;
        for (i = 0; i < N_ILLEGAL; i++) begin
            t = random_instr(bad_ops[rand_bits(2)]);
            step_cycle(t, 1'b1);
            // Read back the destination that the illegal instruction named
            t.op        = OP_A;
            t.src_a     = t.dst;
            t.use_imm   = 1'b0;
            t.use_carry = 1'b0;
            step_cycle(t, 1'b1);
        end
        finish_test("illegal opcodes", errs);

        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
design/alu_types_pkg.sv
design/cpu_instr_pkg.sv
design/alu.sv
design/reg_file.sv
design/alu_exec_stage.sv
design/alu_datapath.sv
bench/tb_clock.sv
bench/tb_alu_datapath.sv

//--- Bender.yml
package:
  name: alu_datapath

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/alu_types_pkg.sv
      - design/cpu_instr_pkg.sv
      - design/alu.sv
      - design/reg_file.sv
      - design/alu_exec_stage.sv
      - design/alu_datapath.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_clock.sv
      - bench/tb_alu_datapath.sv
